// File: Bender.yml
package:
  name: tram

sources:
  # Packages first, the RTL blocks use them by wildcard import
  - source/tram_geom_pkg.sv
  - source/tram_op_pkg.sv
  - source/tram_addr_decoder.sv
  - source/tram_tile.sv
  - source/tram_read_return.sv
  - source/tram_top.sv
  - target: simulation
    files:
      - sim/tram_assert.sv
      - sim/tram_tb.sv

// File: all.f
source/tram_geom_pkg.sv
source/tram_op_pkg.sv
source/tram_addr_decoder.sv
source/tram_tile.sv
source/tram_read_return.sv
source/tram_top.sv
sim/tram_assert.sv
sim/tram_tb.sv

// File: sim/tram_assert.sv
// Tiled RAM decoder assertions
// Concurrent properties on the address decoder, attached to every
// decoder instance with bind.

`timescale 1ns/1ps

module tram_decoder_assert
  import tram_geom_pkg::*;
(
  input logic                  clk,
  input logic                  rst_n,
  input logic                  req_valid,
  input logic [ADDR_WIDTH-1:0] req_addr,
  input logic [TILES-1:0]      tile_valid,
  input logic                  req_err
);

  // Number of assertion failures seen so far, read by the testbench
  int assert_fails = 0;

  // At most one tile is ever selected
  a_tile_onehot : assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(tile_valid))
    else begin
      assert_fails++;
      $error("tile_valid is not one-hot or zero: %b", tile_valid);
    end

  // A request either reaches a tile or errors, never both
  a_err_excl : assert property (@(posedge clk) disable iff (!rst_n)
    !((|tile_valid) && req_err))
    else begin
      assert_fails++;
      $error("tile_valid and req_err are high together");
    end

  // In-range requests always land on exactly one tile
  a_hit_tile : assert property (@(posedge clk) disable iff (!rst_n)
    (req_valid && (req_addr < DEPTH)) |=> $onehot(tile_valid))
    else begin
      assert_fails++;
      $error("in-range request did not select exactly one tile");
    end

  // Out-of-range requests always raise the error pulse
  a_oor_err : assert property (@(posedge clk) disable iff (!rst_n)
    (req_valid && (req_addr >= DEPTH)) |=> req_err)
    else begin
      assert_fails++;
      $error("out-of-range request did not raise req_err");
    end

endmodule : tram_decoder_assert

bind tram_addr_decoder tram_decoder_assert u_decoder_assert (
  .clk        (clk),
  .rst_n      (rst_n),
  .req_valid  (req_valid),
  .req_addr   (req_addr),
  .tile_valid (tile_valid),
  .req_err    (req_err)
);

// File: sim/tram_tb.sv
// Tiled RAM testbench
// Applies a table of requests one per cycle, predicts every read word and
// error pulse from a reference memory, and checks them at the RAM outputs.

`timescale 1ns/1ps

module tram_tb
  import tram_geom_pkg::*;
  import tram_op_pkg::*;
();

  logic                  clk;
  logic                  rst_n;
  logic                  req_valid;
  tram_op_e              req_op;
  logic [ADDR_WIDTH-1:0] req_addr;
  logic [DATA_WIDTH-1:0] req_wdata;
  logic                  rd_valid;
  logic [DATA_WIDTH-1:0] rd_data;
  logic                  req_err;

  // Stimulus table, one row per cycle
  string                 tbl_name[$];
  logic                  tbl_valid[$];
  tram_op_e              tbl_op[$];
  logic [ADDR_WIDTH-1:0] tbl_addr[$];
  logic [DATA_WIDTH-1:0] tbl_wdata[$];

  // Reference memory and the responses still expected, with due cycles
  logic [DATA_WIDTH-1:0] ref_mem [DEPTH];
  string                 rd_name_q[$];
  logic [DATA_WIDTH-1:0] rd_exp_q[$];
  int                    rd_due_q[$];
  string                 err_name_q[$];
  int                    err_due_q[$];

  int    cyc = 0;
  int    cycle_limit = 0;
  int    errors = 0;
  int    checks = 0;
  string cur_name = "reset";
  int    corner_addr[9] = '{0, 3, 7, 8, 12, 15, 16, 19, 23};

  tram_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ----------------------------------------------------------
  // Table building
  // ----------------------------------------------------------

  task automatic add_row(input string name, input logic valid, input tram_op_e op,
                         input int addr, input logic [DATA_WIDTH-1:0] wdata);
    tbl_name.push_back(name);
    tbl_valid.push_back(valid);
    tbl_op.push_back(op);
    tbl_addr.push_back(ADDR_WIDTH'(addr));
    tbl_wdata.push_back(wdata);
  endtask

  task automatic add_write(input string name, input int addr, input logic [DATA_WIDTH-1:0] wdata);
    add_row(name, 1'b1, OP_WRITE, addr, wdata);
  endtask

  task automatic add_read(input string name, input int addr);
    add_row(name, 1'b1, OP_READ, addr, '0);
  endtask

  // ----------------------------------------------------------
  // Driving and prediction
  // ----------------------------------------------------------

  // Puts row i on the inputs and records what the RAM must answer
  // The request is sampled at the next rising edge, number cyc + 1
  task automatic apply_row(input int i);
    int issue;
    issue     = cyc + 1;
    cur_name  = tbl_name[i];
    req_valid = tbl_valid[i];
    req_op    = tbl_op[i];
    req_addr  = tbl_addr[i];
    req_wdata = tbl_wdata[i];
    if (tbl_valid[i]) begin
      if (tbl_addr[i] >= DEPTH) begin
        // Error pulse is visible at the edge after the request
        err_name_q.push_back(tbl_name[i]);
        err_due_q.push_back(issue + 1);
      end else if (tbl_op[i] == OP_WRITE) begin
        ref_mem[tbl_addr[i]] = tbl_wdata[i];
      end else begin
        // Three register stages between request and read data
        rd_name_q.push_back(tbl_name[i]);
        rd_exp_q.push_back(ref_mem[tbl_addr[i]]);
        rd_due_q.push_back(issue + 3);
      end
    end
  endtask

  // ----------------------------------------------------------
  // Output checks
  // ----------------------------------------------------------

  task automatic check_read();
    checks++;
    if (rd_due_q.size() > 0 && rd_due_q[0] == cyc) begin
      if (rd_valid !== 1'b1) begin
        errors++;
        $display("ERR %s rd_valid expected 1 actual %b", rd_name_q[0], rd_valid);
      end else if (rd_data !== rd_exp_q[0]) begin
        errors++;
        $display("ERR %s rd_data expected %h actual %h", rd_name_q[0], rd_exp_q[0], rd_data);
      end
      void'(rd_name_q.pop_front());
      void'(rd_exp_q.pop_front());
      void'(rd_due_q.pop_front());
    end else if (rd_valid !== 1'b0) begin
      errors++;
      $display("ERR %s rd_valid expected 0 actual %b", cur_name, rd_valid);
    end
  endtask

  task automatic check_err();
    checks++;
    if (err_due_q.size() > 0 && err_due_q[0] == cyc) begin
      if (req_err !== 1'b1) begin
        errors++;
        $display("ERR %s req_err expected 1 actual %b", err_name_q[0], req_err);
      end
      void'(err_name_q.pop_front());
      void'(err_due_q.pop_front());
    end else if (req_err !== 1'b0) begin
      errors++;
      $display("ERR %s req_err expected 0 actual %b", cur_name, req_err);
    end
  endtask

  // Outputs are read here before this edge updates them
  always @(posedge clk) begin
    cyc = cyc + 1;
    if (cycle_limit > 0 && cyc >= cycle_limit) begin
      $display("Run timed out at cycle %0d with responses still outstanding", cyc);
      $display("errors=%0d assertion_failures=%0d checks=%0d", errors,
               DUT.u_decoder.u_decoder_assert.assert_fails, checks);
      $display("TB FAILED");
      $finish;
    end else if (rst_n) begin
      check_read();
      check_err();
    end
  end

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------

  initial begin
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req_op    = OP_READ;
    req_addr  = '0;
    req_wdata = '0;
    void'($urandom(32'he5fe652b));

    // First, last and a middle word of every tile
    foreach (corner_addr[i]) add_write("tile_rw", corner_addr[i], DATA_WIDTH'($urandom));
    foreach (corner_addr[i]) add_read("tile_rw", corner_addr[i]);
    // Words on both sides of each tile boundary
    add_write("boundary", 7, 16'h7777);
    add_write("boundary", 8, 16'h8888);
    add_write("boundary", 15, 16'hf0f0);
    add_write("boundary", 16, 16'h1616);
    add_read("boundary", 8);
    add_read("boundary", 7);
    add_read("boundary", 16);
    add_read("boundary", 15);
    add_write("boundary", 8, 16'h0008);
    add_read("boundary", 7);
    add_read("boundary", 8);
    add_write("boundary", 15, 16'h0015);
    add_read("boundary", 16);
    // Reads in consecutive cycles hopping between tiles
    add_read("b2b_read", 0);
    add_read("b2b_read", 8);
    add_read("b2b_read", 16);
    add_read("b2b_read", 23);
    add_read("b2b_read", 15);
    add_read("b2b_read", 7);
    // Every unmapped address with both opcodes
    for (int a = DEPTH; a < 32; a++) begin
      if (a % 2 == 0) add_write("out_of_range", a, DATA_WIDTH'($urandom));
      else add_read("out_of_range", a);
    end
    add_read("oor_after", 0);
    add_read("oor_after", 7);
    add_read("oor_after", 16);
    add_read("oor_after", 23);
    // Gaps in the request stream, one with a write payload but no valid
    add_row("idle", 1'b0, OP_READ, 0, '0);
    add_row("idle", 1'b0, OP_READ, 0, '0);
    add_row("idle", 1'b0, OP_WRITE, 0, 16'hdead);
    add_read("idle_after", 0);
    // Newest write to a word wins
    add_write("overwrite", 12, DATA_WIDTH'($urandom));
    add_write("overwrite", 12, DATA_WIDTH'($urandom));
    add_read("overwrite", 12);
    add_write("overwrite", 20, 16'h2020);
    add_read("overwrite", 20);
    add_write("overwrite", 20, 16'h2121);
    add_read("overwrite", 20);

    // Reset cycles, the table, read latency and a margin
    cycle_limit = 2 + tbl_name.size() + 3 + 20;

    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    foreach (tbl_name[i]) begin
      @(negedge clk);
      apply_row(i);
    end
    @(negedge clk);
    cur_name  = "idle_tail";
    req_valid = 1'b0;

    // Drain the outstanding responses, then watch a few quiet cycles
    while (rd_due_q.size() > 0 || err_due_q.size() > 0) @(negedge clk);
    repeat (3) @(negedge clk);

    $display("errors=%0d assertion_failures=%0d checks=%0d", errors,
             DUT.u_decoder.u_decoder_assert.assert_fails, checks);
    if (errors == 0 && DUT.u_decoder.u_decoder_assert.assert_fails == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule : tram_tb

// File: source/tram_addr_decoder.sv
// Tiled RAM address decoder
// Compares each request address against the range of every tile, picks
// the one tile that owns it and forwards the local address, opcode and
// write data after one register stage. Addresses past the last tile
// raise a one-cycle error pulse instead of a tile strobe.

`timescale 1ns/1ps

module tram_addr_decoder
  import tram_geom_pkg::*;
  import tram_op_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  // Incoming request, one per cycle at most
  input  logic                       req_valid,
  input  tram_op_e                   req_op,
  input  logic [ADDR_WIDTH-1:0]      req_addr,
  input  logic [DATA_WIDTH-1:0]      req_wdata,
  // Steered request, one valid bit per tile and a shared payload
  output logic [TILES-1:0]           tile_valid,
  output tram_op_e                   tile_op,
  output logic [TILE_ADDR_WIDTH-1:0] tile_addr,
  output logic [DATA_WIDTH-1:0]      tile_wdata,
  // Pulses one cycle after a valid request that hit no tile
  output logic                       req_err
);

  // ----------------------------------------------------------
  // Range compare
  // ----------------------------------------------------------

  // Address widened by one bit so the bound of the last tile always fits,
  // even when the depth is a power of two
  logic [ADDR_WIDTH:0]                   addr_ext;
  // Which tile range the address falls in, one-hot or zero
  logic [TILES-1:0]                      tile_hit;
  // Address minus the base of each tile, only meaningful for the hit tile
  logic [TILES-1:0][TILE_ADDR_WIDTH-1:0] tile_offset;
  // Offset of the selected tile
  logic [TILE_ADDR_WIDTH-1:0]            local_addr;
  // Set when some tile owns the address
  logic                                  in_range;

  assign addr_ext = {1'b0, req_addr};

  for (genvar i = 0; i < TILES; i++) begin : gen_range
    // First word of this tile, inclusive
    localparam logic [ADDR_WIDTH:0] TILE_BASE  = (ADDR_WIDTH + 1)'(TILE_DEPTH * i);
    // First word of the next tile, exclusive
    localparam logic [ADDR_WIDTH:0] TILE_BOUND = (ADDR_WIDTH + 1)'(TILE_DEPTH * (i + 1));

    // Tile 0 has a base of zero so its lower compare is always true
    assign tile_hit[i] = (addr_ext >= TILE_BASE) && (addr_ext < TILE_BOUND);

    // Only the low bits survive, which is all a tile can index
    assign tile_offset[i] = TILE_ADDR_WIDTH'(addr_ext - TILE_BASE);
  end

  // The tile ranges do not overlap, so at most one offset passes the gate
  // and a plain OR picks it without a priority chain
  always_comb begin
    local_addr = '0;
    for (int i = 0; i < TILES; i++) begin
      local_addr |= tile_offset[i] & {TILE_ADDR_WIDTH{tile_hit[i]}};
    end
  end

  // Everything at or past DEPTH misses all tiles
  assign in_range = |tile_hit;

  // ----------------------------------------------------------
  // Output register stage
  // ----------------------------------------------------------

  // One valid flop per tile plus the error flop
  // An idle cycle clears all of them so every strobe lasts one cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tile_valid <= '0;
      req_err    <= 1'b0;
    end else begin
      tile_valid <= tile_hit & {TILES{req_valid}};
      req_err    <= req_valid && !in_range;
    end
  end

  // Shared payload for all tiles
  // Only the tile whose valid is set acts on it
  // It loads on any valid request, so an erroring one also lands here,
  // which is harmless since no tile is selected in that cycle
  always_ff @(posedge clk) begin
    if (req_valid) begin
      tile_op    <= req_op;
      tile_addr  <= local_addr;
      tile_wdata <= req_wdata;
    end
  end

endmodule : tram_addr_decoder

// File: source/tram_geom_pkg.sv
// Tiled RAM geometry
// Word count, tile split and the address and data widths that follow
// from them. Every block of the RAM sizes itself from these constants.

package tram_geom_pkg;

  // ----------------------------------------------------------
  // Storage size
  // ----------------------------------------------------------

  // Total number of words in the RAM
  // Need not be a power of two since the decoder uses range compares
  localparam int DEPTH = 24;

  // Number of equal tiles the words are split across
  // Must divide DEPTH evenly
  localparam int TILES = 3;

  // Words held by one tile
  localparam int TILE_DEPTH = DEPTH / TILES;

  // ----------------------------------------------------------
  // Widths
  // ----------------------------------------------------------

  // Bits per stored word
  localparam int DATA_WIDTH = 16;

  // Global request address, wide enough for every word
  // With 24 words this gives 5 bits, so 24..31 are out of range
  localparam int ADDR_WIDTH = $clog2(DEPTH);

  // Address inside one tile after the tile base is removed
  localparam int TILE_ADDR_WIDTH = $clog2(TILE_DEPTH);

endpackage : tram_geom_pkg

// File: source/tram_op_pkg.sv
// Tiled RAM request opcodes
// A request either reads one word or writes one word.

package tram_op_pkg;

  // ----------------------------------------------------------
  // Request opcode
  // ----------------------------------------------------------

  // One bit is enough since there are only two kinds of request
  // Reads come back on the read-return path three cycles later
  // Writes give no response at all
  typedef enum logic {
    // Fetch the addressed word
    OP_READ  = 1'b0,
    // Store the write data at the addressed word
    OP_WRITE = 1'b1
  } tram_op_e;

endpackage : tram_op_pkg

// File: source/tram_read_return.sv
// Tiled RAM read return
// Collects the read response of whichever tile answered this cycle and
// registers it as the RAM read output. At most one tile answers per
// cycle, so the tiles are merged with a gated OR.

`timescale 1ns/1ps

module tram_read_return
  import tram_geom_pkg::*;
(
  input  logic                              clk,
  input  logic                              rst_n,
  // Read responses from all tiles, one valid bit per tile
  input  logic [TILES-1:0]                  tile_rvalid,
  input  logic [TILES-1:0][DATA_WIDTH-1:0]  tile_rdata,
  // Merged read response at the RAM boundary
  output logic                              rd_valid,
  output logic [DATA_WIDTH-1:0]             rd_data
);

  // ----------------------------------------------------------
  // Merge
  // ----------------------------------------------------------

  // Data of the answering tile, zero if none answered
  logic [DATA_WIDTH-1:0] merged_rdata;
  // Set when any tile answered this cycle
  logic                  any_rvalid;

  // Each tile holds its old rdata between reads, so the data must be
  // masked with its own valid before the OR
  // One request per cycle upstream keeps the valids one-hot or zero
  always_comb begin
    merged_rdata = '0;
    for (int i = 0; i < TILES; i++) begin
      merged_rdata |= tile_rdata[i] & {DATA_WIDTH{tile_rvalid[i]}};
    end
  end

  assign any_rvalid = |tile_rvalid;

  // ----------------------------------------------------------
  // Output register
  // ----------------------------------------------------------

  // Valid is a one-cycle pulse, one cycle after the tile answered
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= any_rvalid;
    end
  end

  // Data only moves when a tile answers
  // Between reads the last returned word stays on rd_data
  always_ff @(posedge clk) begin
    if (any_rvalid) begin
      rd_data <= merged_rdata;
    end
  end

endmodule : tram_read_return

// File: source/tram_tile.sv
// Tiled RAM storage tile
// One synchronous single-port array of TILE_DEPTH words. Writes land on
// the edge that samples the select, reads return one cycle later with a
// one-cycle valid strobe.

`timescale 1ns/1ps

module tram_tile
  import tram_geom_pkg::*;
  import tram_op_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  // Request from the decoder, acted on only while sel is high
  input  logic                       sel,
  input  tram_op_e                   op,
  input  logic [TILE_ADDR_WIDTH-1:0] addr,
  input  logic [DATA_WIDTH-1:0]      wdata,
  // Read response toward the read-return stage
  output logic                       rvalid,
  output logic [DATA_WIDTH-1:0]      rdata
);

  // ----------------------------------------------------------
  // Storage
  // ----------------------------------------------------------

  // The word array itself
  // Contents are undefined until written
  logic [DATA_WIDTH-1:0] mem [TILE_DEPTH];

  // Decoded request kind for this cycle
  logic wr_en;
  logic rd_en;

  assign wr_en = sel && (op == OP_WRITE);
  assign rd_en = sel && (op == OP_READ);

  // Write port
  // The decoder only ever sends local addresses below TILE_DEPTH
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[addr] <= wdata;
    end
  end

  // ----------------------------------------------------------
  // Read port
  // ----------------------------------------------------------

  // Registered read, so the word shows up one cycle after the select
  // rdata keeps the last word read while no read is in progress
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rdata <= mem[addr];
    end
  end

  // Valid strobe paired with the registered read data
  // It follows rd_en by one cycle and is low otherwise
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid <= 1'b0;
    end else begin
      rvalid <= rd_en;
    end
  end

endmodule : tram_tile

// File: source/tram_top.sv
// Tiled RAM top level
// Single-port RAM of DEPTH words split into TILES equal tiles. Requests
// go through the address decoder into one tile, and read data comes back
// through the read-return stage three cycles after the request.

`timescale 1ns/1ps

module tram_top
  import tram_geom_pkg::*;
  import tram_op_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  // Request side, one request per cycle and never stalled
  input  logic                  req_valid,
  input  tram_op_e              req_op,
  input  logic [ADDR_WIDTH-1:0] req_addr,
  input  logic [DATA_WIDTH-1:0] req_wdata,
  // Read response, three cycles after the read request
  output logic                  rd_valid,
  output logic [DATA_WIDTH-1:0] rd_data,
  // Out-of-range pulse, one cycle after the request
  output logic                  req_err
);

  // ----------------------------------------------------------
  // Internal nets
  // ----------------------------------------------------------

  // Decoder to tiles
  // Only the valid is per tile, the payload is shared
  logic [TILES-1:0]                 tile_valid;
  tram_op_e                         tile_op;
  logic [TILE_ADDR_WIDTH-1:0]       tile_addr;
  logic [DATA_WIDTH-1:0]            tile_wdata;

  // Tiles to read return
  logic [TILES-1:0]                 tile_rvalid;
  logic [TILES-1:0][DATA_WIDTH-1:0] tile_rdata;

  // ----------------------------------------------------------
  // Blocks
  // ----------------------------------------------------------

  // First cycle, pick the tile
  tram_addr_decoder u_decoder (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req_op     (req_op),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .tile_valid (tile_valid),
    .tile_op    (tile_op),
    .tile_addr  (tile_addr),
    .tile_wdata (tile_wdata),
    .req_err    (req_err)
  );

  // Second cycle, access the array of the selected tile
  for (genvar i = 0; i < TILES; i++) begin : gen_tile
    tram_tile u_tile (
      .clk    (clk),
      .rst_n  (rst_n),
      .sel    (tile_valid[i]),
      .op     (tile_op),
      .addr   (tile_addr),
      .wdata  (tile_wdata),
      .rvalid (tile_rvalid[i]),
      .rdata  (tile_rdata[i])
    );
  end

  // Third cycle, merge the answering tile onto the output
  tram_read_return u_read_return (
    .clk         (clk),
    .rst_n       (rst_n),
    .tile_rvalid (tile_rvalid),
    .tile_rdata  (tile_rdata),
    .rd_valid    (rd_valid),
    .rd_data     (rd_data)
  );

endmodule : tram_top
